//--- Bender.yml
package:
  name: lbm_core

sources:
  - files:
      - lbm_pkg.sv
      - lbm_lane_if.sv
      - lbm_lattice_mem.sv
      - lbm_sweep_fetch.sv
      - lbm_stream_lane.sv
      - lbm_write_back.sv
      - lbm_wb_regs.sv
      - lbm_core.sv
  - target: test
    files:
      - tb_lbm_core.sv

//--- lbm_core.f
lbm_pkg.sv
lbm_lane_if.sv
lbm_lattice_mem.sv
lbm_sweep_fetch.sv
lbm_stream_lane.sv
lbm_write_back.sv
lbm_wb_regs.sv
lbm_core.sv
tb_lbm_core.sv

//--- lbm_core.sv
`timescale 1ns/1ps

module lbm_core import lbm_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [adr_w-1:0] wb_adr,
    input  logic [bus_w-1:0] wb_dat_w,
    output logic [bus_w-1:0] wb_dat_r,
    output logic wb_ack,
    output logic busy
);

    // host side
    logic [adr_w-1:0] host_adr;
    logic host_we;
    logic [bus_w-1:0] host_wdata;
    logic [bus_w-1:0] host_rdata;
    logic start;
    logic step_done;

    // gather side
    cell_t gather_adr [lanes][dirs];
    cell_t own_adr [lanes];
    dist_t gather_dist [lanes][dirs];
    logic gather_bar [lanes][dirs];
    dist_t own_dist [lanes][dirs];
    logic own_bar [lanes];

    // write-back side
    logic wr_en;
    cell_t wr_cell;
    dist_t wr_dist [lanes][dirs];
    rho_t wr_rho [lanes];

    lbm_lane_if lane_bus ();

    lbm_wb_regs lbm_wb_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .host_adr   (host_adr),
        .host_we    (host_we),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .start      (start),
        .step_done  (step_done),
        .busy       (busy)
    );

    lbm_lattice_mem lbm_lattice_mem_inst (
        .clk         (clk),
        .rst         (rst),
        .host_adr    (host_adr),
        .host_we     (host_we),
        .host_wdata  (host_wdata),
        .host_rdata  (host_rdata),
        .gather_adr  (gather_adr),
        .own_adr     (own_adr),
        .gather_dist (gather_dist),
        .gather_bar  (gather_bar),
        .own_dist    (own_dist),
        .own_bar     (own_bar),
        .wr_en       (wr_en),
        .wr_cell     (wr_cell),
        .wr_dist     (wr_dist),
        .wr_rho      (wr_rho),
        .step_done   (step_done)
    );

    lbm_sweep_fetch lbm_sweep_fetch_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .gather_adr  (gather_adr),
        .own_adr     (own_adr),
        .gather_dist (gather_dist),
        .gather_bar  (gather_bar),
        .own_dist    (own_dist),
        .own_bar     (own_bar),
        .lane_if     (lane_bus.feed)
    );

    // one lane per cell of a group
    generate
        for (genvar l = 0; l < lanes; l++)
        begin : g_lane
            lbm_stream_lane #(
                .lane_id (l)
            ) lbm_stream_lane_inst (
                .clk     (clk),
                .rst     (rst),
                .lane_if (lane_bus.lane)
            );
        end
    endgenerate

    lbm_write_back lbm_write_back_inst (
        .clk       (clk),
        .rst       (rst),
        .lane_if   (lane_bus.drain),
        .wr_en     (wr_en),
        .wr_cell   (wr_cell),
        .wr_dist   (wr_dist),
        .wr_rho    (wr_rho),
        .step_done (step_done)
    );

endmodule

//--- lbm_lane_if.sv
`timescale 1ns/1ps

interface lbm_lane_if import lbm_pkg::*; ();

    // group issued by the fetch stage
    logic valid;
    logic last;
    cell_t base;
    dist_t up_dist [lanes][dirs];
    dist_t opp_dist [lanes][dirs];
    logic up_blk [lanes][dirs];
    logic own_bar [lanes];

    // one cycle later, from the lanes
    dist_t res_dist [lanes][dirs];
    rho_t res_rho [lanes];

    modport feed (
        output valid, last, base, up_dist, opp_dist, up_blk, own_bar
    );

    modport lane (
        input  valid, up_dist, opp_dist, up_blk, own_bar,
        output res_dist, res_rho
    );

    modport drain (
        input valid, last, base, res_dist, res_rho
    );

endinterface

//--- lbm_lattice_mem.sv
`timescale 1ns/1ps

module lbm_lattice_mem import lbm_pkg::*;
(
    input  logic clk,
    input  logic rst,
    // host port
    input  logic [adr_w-1:0] host_adr,
    input  logic host_we,
    input  logic [bus_w-1:0] host_wdata,
    output logic [bus_w-1:0] host_rdata,
    // gather port
    input  cell_t gather_adr [lanes][dirs],
    input  cell_t own_adr [lanes],
    output dist_t gather_dist [lanes][dirs],
    output logic gather_bar [lanes][dirs],
    output dist_t own_dist [lanes][dirs],
    output logic own_bar [lanes],
    // write-back port
    input  logic wr_en,
    input  cell_t wr_cell,
    input  dist_t wr_dist [lanes][dirs],
    input  rho_t wr_rho [lanes],
    input  logic step_done
);

    dist_t dist_mem [2][dirs][cells];
    rho_t rho_mem [cells];
    logic [cells-1:0] barrier;
    logic cur;

    region_t h_region;
    logic [3:0] h_dir;
    cell_t h_cell;

    assign h_region = region_t'(host_adr[11:10]);
    assign h_dir = host_adr[9:6];
    assign h_cell = host_adr[5:0];

    // host reads
    always_comb
    begin
        case (h_region)
            region_dist:
                host_rdata = (h_dir < dirs) ? bus_w'(dist_mem[cur][h_dir][h_cell]) : '0;
            region_barrier:
                host_rdata = bus_w'(barrier[h_cell]);
            region_rho:
                host_rdata = bus_w'(rho_mem[h_cell]);
            default:
                host_rdata = '0;
        endcase
    end

    // gather reads, all from the current bank
    always_comb
    begin
        for (int l = 0; l < lanes; l++)
        begin
            own_bar[l] = barrier[own_adr[l]];
            for (int d = 0; d < dirs; d++)
            begin
                gather_dist[l][d] = dist_mem[cur][d][gather_adr[l][d]];
                gather_bar[l][d] = barrier[gather_adr[l][d]];
                own_dist[l][d] = dist_mem[cur][d][own_adr[l]];
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            cur <= 1'b0;
            barrier <= '0;
        end
        else
        begin
            if (step_done)
                cur <= ~cur;
            if (host_we && h_region == region_barrier)
                barrier[h_cell] <= host_wdata[0];
        end
    end

    // host writes the current bank, write-back the next one
    always_ff @(posedge clk)
    begin
        if (host_we && h_region == region_dist && h_dir < dirs)
            dist_mem[cur][h_dir][h_cell] <= host_wdata[data_w-1:0];
        if (wr_en)
        begin
            for (int l = 0; l < lanes; l++)
            begin
                rho_mem[cell_t'(wr_cell + l)] <= wr_rho[l];
                for (int d = 0; d < dirs; d++)
                    dist_mem[~cur][d][cell_t'(wr_cell + l)] <= wr_dist[l][d];
            end
        end
    end

endmodule

//--- lbm_pkg.sv
package lbm_pkg;

    ////////////////////////////////////////////////////////////
    // lattice geometry
    ////////////////////////////////////////////////////////////

    localparam int grid_w = 8;
    localparam int grid_h = 8;
    localparam int cells = grid_w * grid_h;
    localparam int dirs = 9;
    localparam int lanes = 4;
    localparam int groups = cells / lanes;
    localparam int data_w = 16;
    // nine values summed, so four extra bits
    localparam int rho_w = data_w + 4;
    localparam int cell_w = 6;

    // wishbone address and data widths
    localparam int adr_w = 12;
    localparam int bus_w = 32;

    typedef logic [data_w-1:0] dist_t;
    typedef logic [rho_w-1:0] rho_t;
    typedef logic [cell_w-1:0] cell_t;

    // fixed order, shared with the testbench model
    typedef enum logic [3:0] {
        dir_c, dir_n, dir_ne, dir_e, dir_se, dir_s, dir_sw, dir_w, dir_nw
    } dir_t;

    typedef enum logic {sweep_idle, sweep_run} sweep_state_t;

    // address bits 11:10
    typedef enum logic [1:0] {
        region_ctrl, region_dist, region_barrier, region_rho
    } region_t;

    // address bit 0 inside region_ctrl
    typedef enum logic {reg_steps, reg_status} reg_sel_t;

    ////////////////////////////////////////////////////////////
    // direction helpers, y grows towards the south
    ////////////////////////////////////////////////////////////

    function automatic int dir_dx(int d);
        case (dir_t'(d))
            dir_ne, dir_e, dir_se: return 1;
            dir_sw, dir_w, dir_nw: return -1;
            default: return 0;
        endcase
    endfunction

    function automatic int dir_dy(int d);
        case (dir_t'(d))
            dir_nw, dir_n, dir_ne: return -1;
            dir_sw, dir_s, dir_se: return 1;
            default: return 0;
        endcase
    endfunction

    // moving ones rotate by half a turn, rest stays put
    function automatic int dir_opp(int d);
        return (d == int'(dir_c)) ? d : ((d + 3) % 8) + 1;
    endfunction

endpackage

//--- lbm_stream_lane.sv
`timescale 1ns/1ps

module lbm_stream_lane import lbm_pkg::*;
#(
    parameter int lane_id = 0
)
(
    input  logic clk,
    input  logic rst,
    lbm_lane_if.lane lane_if
);

    dist_t nxt [dirs];
    rho_t sum;
    dist_t res_q [dirs];
    rho_t rho_q;

    // pull from upstream, reflect where blocked
    always_comb
    begin
        sum = '0;
        for (int d = 0; d < dirs; d++)
        begin
            if (lane_if.own_bar[lane_id])
                nxt[d] = '0;
            else if (lane_if.up_blk[lane_id][d])
                nxt[d] = lane_if.opp_dist[lane_id][d];
            else
                nxt[d] = lane_if.up_dist[lane_id][d];
            sum = sum + rho_t'(nxt[d]);
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rho_q <= '0;
            for (int d = 0; d < dirs; d++)
                res_q[d] <= '0;
        end
        else if (lane_if.valid)
        begin
            rho_q <= sum;
            res_q <= nxt;
        end
    end

    assign lane_if.res_dist[lane_id] = res_q;
    assign lane_if.res_rho[lane_id] = rho_q;

endmodule

//--- lbm_sweep_fetch.sv
`timescale 1ns/1ps

module lbm_sweep_fetch import lbm_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    output cell_t gather_adr [lanes][dirs],
    output cell_t own_adr [lanes],
    input  dist_t gather_dist [lanes][dirs],
    input  logic gather_bar [lanes][dirs],
    input  dist_t own_dist [lanes][dirs],
    input  logic own_bar [lanes],
    lbm_lane_if.feed lane_if
);

    sweep_state_t state;
    logic [$clog2(groups)-1:0] grp;
    logic outside [lanes][dirs];

    ////////////////////////////////////////////////////////////
    // upstream cell of every lane and direction
    ////////////////////////////////////////////////////////////

    always_comb
    begin : upstream
        int c;
        int x;
        int y;
        int ux;
        int uy;
        for (int l = 0; l < lanes; l++)
        begin
            c = int'(grp) * lanes + l;
            x = c % grid_w;
            y = c / grid_w;
            own_adr[l] = cell_t'(c);
            for (int d = 0; d < dirs; d++)
            begin
                ux = x - dir_dx(d);
                uy = y - dir_dy(d);
                outside[l][d] = (ux < 0) || (ux >= grid_w) || (uy < 0) || (uy >= grid_h);
                // off-grid pulls just look at the own cell
                gather_adr[l][d] = outside[l][d] ? cell_t'(c) : cell_t'(uy * grid_w + ux);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sweep fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= sweep_idle;
            grp <= '0;
            lane_if.valid <= 1'b0;
            lane_if.last <= 1'b0;
        end
        else
        begin
            lane_if.valid <= 1'b0;
            lane_if.last <= 1'b0;
            case (state)
                sweep_idle:
                begin
                    grp <= '0;
                    if (start)
                        state <= sweep_run;
                end
                sweep_run:
                begin
                    lane_if.valid <= 1'b1;
                    lane_if.last <= (grp == groups - 1);
                    grp <= grp + 1'b1;
                    if (grp == groups - 1)
                        state <= sweep_idle;
                end
                default:
                    state <= sweep_idle;
            endcase
        end
    end

    // gathered values, only latched while sweeping
    always_ff @(posedge clk)
    begin
        if (state == sweep_run)
        begin
            lane_if.base <= cell_t'(int'(grp) * lanes);
            for (int l = 0; l < lanes; l++)
            begin
                lane_if.own_bar[l] <= own_bar[l];
                for (int d = 0; d < dirs; d++)
                begin
                    lane_if.up_dist[l][d] <= gather_dist[l][d];
                    lane_if.up_blk[l][d] <= outside[l][d] || gather_bar[l][d];
                    lane_if.opp_dist[l][d] <= own_dist[l][dir_opp(d)];
                end
            end
        end
    end

endmodule

//--- lbm_wb_regs.sv
`timescale 1ns/1ps

module lbm_wb_regs import lbm_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic wb_cyc,
    input  logic wb_stb,
    input  logic wb_we,
    input  logic [adr_w-1:0] wb_adr,
    input  logic [bus_w-1:0] wb_dat_w,
    output logic [bus_w-1:0] wb_dat_r,
    output logic wb_ack,
    output logic [adr_w-1:0] host_adr,
    output logic host_we,
    output logic [bus_w-1:0] host_wdata,
    input  logic [bus_w-1:0] host_rdata,
    output logic start,
    input  logic step_done,
    output logic busy
);

    region_t region;
    reg_sel_t reg_sel;
    logic req;
    logic steps_wr;
    logic load_q;
    logic [15:0] steps_left;
    logic [15:0] steps_done;
    logic [bus_w-1:0] rdata;

    assign region = region_t'(wb_adr[11:10]);
    assign reg_sel = reg_sel_t'(wb_adr[0]);

    // new request only, the ack cycle masks it
    assign req = wb_cyc && wb_stb && !wb_ack;

    assign steps_wr = req && wb_we && !busy && region == region_ctrl
        && reg_sel == reg_steps && wb_dat_w[15:0] != '0;

    // memory window, writes dropped during a run
    assign host_adr = wb_adr;
    assign host_wdata = wb_dat_w;
    assign host_we = req && wb_we && !busy && region != region_ctrl;

    always_comb
    begin
        if (region != region_ctrl)
            rdata = host_rdata;
        else if (reg_sel == reg_status)
            rdata = {steps_done, 15'b0, busy};
        else
            rdata = '0;
    end

    ////////////////////////////////////////////////////////////
    // ack and step sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wb_ack <= 1'b0;
            load_q <= 1'b0;
            start <= 1'b0;
            busy <= 1'b0;
            steps_left <= '0;
            steps_done <= '0;
        end
        else
        begin
            wb_ack <= req;
            load_q <= steps_wr;
            start <= 1'b0;
            if (steps_wr)
            begin
                steps_left <= wb_dat_w[15:0];
                steps_done <= '0;
            end
            // run begins the cycle after the ack
            if (load_q)
            begin
                busy <= 1'b1;
                start <= 1'b1;
                steps_left <= steps_left - 1'b1;
            end
            if (step_done)
            begin
                steps_done <= steps_done + 1'b1;
                if (steps_left != '0)
                begin
                    start <= 1'b1;
                    steps_left <= steps_left - 1'b1;
                end
                else
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req)
            wb_dat_r <= rdata;
    end

endmodule

//--- lbm_write_back.sv
`timescale 1ns/1ps

module lbm_write_back import lbm_pkg::*;
(
    input  logic clk,
    input  logic rst,
    lbm_lane_if.drain lane_if,
    output logic wr_en,
    output cell_t wr_cell,
    output dist_t wr_dist [lanes][dirs],
    output rho_t wr_rho [lanes],
    output logic step_done
);

    // feed tags delayed to line up with the lane registers
    logic valid_d;
    logic last_d;
    cell_t base_d;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            valid_d <= 1'b0;
            last_d <= 1'b0;
            wr_en <= 1'b0;
            step_done <= 1'b0;
        end
        else
        begin
            valid_d <= lane_if.valid;
            last_d <= lane_if.valid && lane_if.last;
            wr_en <= valid_d;
            // same cycle as the write of group 15
            step_done <= valid_d && last_d;
        end
    end

    always_ff @(posedge clk)
    begin
        base_d <= lane_if.base;
        if (valid_d)
        begin
            wr_cell <= base_d;
            wr_dist <= lane_if.res_dist;
            wr_rho <= lane_if.res_rho;
        end
    end

endmodule

//--- tb_lbm_core.sv
`timescale 1ns/1ps

module tb_lbm_core import lbm_pkg::*; ();

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [11:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic wb_ack;
    logic busy;

    ////////////////////////////////////////////////////////////
    // test table
    ////////////////////////////////////////////////////////////

    localparam int pat_none = 0;
    localparam int pat_cross = 1;

    typedef enum {
        prop_stream, prop_bounce, prop_rho, prop_count,
        prop_mass_fluid, prop_mass_all, prop_busy_write
    } prop_t;

    typedef struct {
        string name;
        int pattern;
        int steps;
        prop_t prop;
    } test_t;

    localparam int num_tests = 7;
    test_t tests [num_tests];

    // d2q9 in c n ne e se s sw w nw order
    // y grows southwards
    int dx_tab [9] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    int dy_tab [9] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};
    int opp_tab [9] = '{0, 5, 6, 7, 8, 1, 2, 3, 4};

    // reference lattice and read-back copies
    int m_f [dirs][cells];
    int init_f [dirs][cells];
    bit m_bar [cells];
    int rd_f [dirs][cells];
    int rd_rho [cells];
    int rd_bar [cells];

    int error_count;
    int pass_count;
    int fail_count;
    bit hung;

    lbm_core lbm_core_inst (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .busy     (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // checks and bus access
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic bus_access(input logic we, input logic [11:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        rdata = '0;
        waited = 0;
        if (hung)
            return;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdata;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wb_ack && waited < 20);
        if (wb_ack)
            rdata = wb_dat_r;
        else
        begin
            $display("timeout: no wb_ack within 20 cycles at address %0h", adr);
            error_count++;
            hung = 1'b1;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [11:0] adr, output logic [31:0] data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        if (hung)
            return;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (busy && waited < 2000);
        if (busy)
        begin
            $display("timeout: busy still high after 2000 cycles");
            error_count++;
            hung = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model of one stream step
    ////////////////////////////////////////////////////////////

    task automatic model_step();
        int nf [dirs][cells];
        int x;
        int y;
        int ux;
        int uy;
        for (int c = 0; c < cells; c++)
        begin
            x = c % grid_w;
            y = c / grid_w;
            for (int d = 0; d < dirs; d++)
            begin
                ux = x - dx_tab[d];
                uy = y - dy_tab[d];
                if (m_bar[c])
                    nf[d][c] = 0;
                else if (ux < 0 || ux >= grid_w || uy < 0 || uy >= grid_h)
                    nf[d][c] = m_f[opp_tab[d]][c];
                else if (m_bar[uy * grid_w + ux])
                    nf[d][c] = m_f[opp_tab[d]][c];
                else
                    nf[d][c] = m_f[d][uy * grid_w + ux];
            end
        end
        m_f = nf;
    endtask

    task automatic load_lattice();
        for (int c = 0; c < cells; c++)
            bus_write({2'b10, 4'b0, 6'(c)}, 32'(m_bar[c]));
        for (int d = 0; d < dirs; d++)
            for (int c = 0; c < cells; c++)
                bus_write({2'b01, 4'(d), 6'(c)}, 32'(m_f[d][c]));
    endtask

    task automatic read_lattice();
        logic [31:0] v;
        for (int c = 0; c < cells; c++)
        begin
            bus_read({2'b10, 4'b0, 6'(c)}, v);
            rd_bar[c] = int'(v);
            bus_read({2'b11, 4'b0, 6'(c)}, v);
            rd_rho[c] = int'(v);
        end
        for (int d = 0; d < dirs; d++)
            for (int c = 0; c < cells; c++)
            begin
                bus_read({2'b01, 4'(d), 6'(c)}, v);
                rd_f[d][c] = int'(v);
            end
    endtask

    ////////////////////////////////////////////////////////////
    // one table entry
    ////////////////////////////////////////////////////////////

    task automatic run_test(input test_t tc);
        logic [31:0] status;
        int x;
        int y;
        int sum;
        int mass_in;
        int mass_out;
        for (int c = 0; c < cells; c++)
        begin
            x = c % grid_w;
            y = c / grid_w;
            m_bar[c] = (tc.pattern == pat_cross)
                && ((x == 3 && y >= 1 && y <= 6) || (y == 4 && x >= 1 && x <= 6));
        end
        for (int d = 0; d < dirs; d++)
            for (int c = 0; c < cells; c++)
                if (tc.prop == prop_mass_all && m_bar[c])
                    m_f[d][c] = 0;
                else
                    m_f[d][c] = int'($urandom % 1024);
        init_f = m_f;
        load_lattice();
        repeat (tc.steps) model_step();

        bus_write(12'h000, 32'(tc.steps));
        if (tc.prop == prop_busy_write)
        begin
            // lands mid-run and must leave the lattice alone
            @(negedge clk);
            check_value("busy", 32'd1, 32'(busy));
            bus_write({2'b01, 4'd3, 6'd20}, 32'h0000_beef);
        end
        wait_idle();
        if (hung)
            return;

        bus_read(12'h001, status);
        check_value("status.busy", 32'd0, 32'(status[0]));
        check_value("status.steps", 32'(tc.steps), 32'(status[31:16]));
        read_lattice();
        if (hung)
            return;

        for (int c = 0; c < cells; c++)
        begin
            check_value($sformatf("barrier[%0d]", c), 32'(m_bar[c]), 32'(rd_bar[c]));
            sum = 0;
            for (int d = 0; d < dirs; d++)
            begin
                check_value($sformatf("dist[%0d][%0d]", d, c), 32'(m_f[d][c]),
                            32'(rd_f[d][c]));
                if (tc.prop == prop_bounce && m_bar[c])
                    check_value($sformatf("barrier dist[%0d][%0d]", d, c), 32'd0,
                                32'(rd_f[d][c]));
                sum += m_f[d][c];
            end
            check_value($sformatf("rho[%0d]", c), 32'(sum), 32'(rd_rho[c]));
        end

        // mass over fluid cells or over every cell
        if (tc.prop == prop_mass_fluid || tc.prop == prop_mass_all)
        begin
            mass_in = 0;
            mass_out = 0;
            for (int c = 0; c < cells; c++)
                if (tc.prop == prop_mass_all || !m_bar[c])
                    for (int d = 0; d < dirs; d++)
                    begin
                        mass_in += init_f[d][c];
                        mass_out += rd_f[d][c];
                    end
            check_value("total mass", 32'(mass_in), 32'(mass_out));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : main
        int errs_before;
        rst <= 1'b0;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        wb_adr <= '0;
        wb_dat_w <= '0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        hung = 1'b0;
        void'($urandom(32'h7c6e_c4a0));

        tests[0] = '{"free streaming", pat_none, 1, prop_stream};
        tests[1] = '{"bounce-back at cross", pat_cross, 1, prop_bounce};
        tests[2] = '{"rho after one step", pat_cross, 1, prop_rho};
        tests[3] = '{"three steps", pat_cross, 3, prop_count};
        tests[4] = '{"fluid mass, two steps", pat_cross, 2, prop_mass_fluid};
        tests[5] = '{"total mass, four steps", pat_cross, 4, prop_mass_all};
        tests[6] = '{"write while busy", pat_cross, 2, prop_busy_write};

        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        for (int t = 0; t < num_tests && !hung; t++)
        begin
            errs_before = error_count;
            run_test(tests[t]);
            if (error_count == errs_before)
            begin
                pass_count++;
                $display("test %0d %s: ok", t, tests[t].name);
            end
            else
            begin
                fail_count++;
                $display("test %0d %s: %0d errors", t, tests[t].name,
                         error_count - errs_before);
            end
        end

        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (error_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
